// File: logic/am_pkg.sv
package am_pkg;

	// ********************
	// Board geometry
	// ********************
	localparam int n_layers   = 6;	// Detector layers, one FIFO each
	localparam int n_lambs    = 4;	// Pattern-matching boards
	localparam int lamb_idx_w = $clog2(n_lambs);

	// Word widths
	localparam int hit_w  = 18;
	localparam int road_w = 21;	// Road address from a LAMB
	localparam int tag_w  = 16;	// Event tag in end-event words

	// ********************
	// Word formats
	// ********************

	// Layer FIFO word, 21 bits
	typedef struct packed {
		logic             ee;	// End-event flag
		logic [1:0]       spare;
		logic [hit_w-1:0] payload;	// Hit, or tag in low bits on end-event
	} layer_word_t;

	// Hit broadcast to all LAMBs, fanned out on the board
	typedef struct packed {
		logic [n_layers-1:0][hit_w-1:0] hit;	// One slot per layer
		logic [n_layers-1:0]            wr_en;	// Slot k written this cycle
	} hit_bus_t;

	// Output word, 24 bits
	typedef struct packed {
		logic                  ee;	// End-event flag
		logic [lamb_idx_w-1:0] lamb;	// Source board, zero on end-event
		logic [road_w-1:0]     payload;	// Road, or tag in low bits
	} road_word_t;

endpackage

// File: logic/word_skid.sv
`timescale 1ns/1ns

module word_skid #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  payload_t in_data,
	input  logic     in_valid,
	output logic     in_ready,
	output payload_t out_data,
	output logic     out_valid,
	input  logic     out_ready
);

	payload_t skid_data;	// Parking slot while output stalls
	logic     skid_valid;
	logic     in_fire;
	logic     out_free;	// Output slot can load this cycle

	// Ready comes from a flop, never from out_ready
	assign in_ready = ~skid_valid;
	assign in_fire  = in_valid & in_ready;
	assign out_free = out_ready | ~out_valid;

	// Control flags
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid  <= 1'b0;
			skid_valid <= 1'b0;
		end else if (out_free) begin
			out_valid  <= skid_valid | in_fire;	// Parked word goes first
			skid_valid <= 1'b0;
		end else if (in_fire) begin
			skid_valid <= 1'b1;	// Output held, park new word
		end
	end

	// Payload, no reset needed
	always_ff @(posedge clk) begin
		if (out_free) begin
			out_data <= skid_valid ? skid_data : in_data;
		end else if (in_fire) begin
			skid_data <= in_data;
		end
	end

endmodule

// File: logic/layer_input.sv
`timescale 1ns/1ns

module layer_input (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  logic [am_pkg::n_layers-1:0]                ef_b,	// Low when FIFO empty
	output logic [am_pkg::n_layers-1:0]                rden_b,	// Active-low read
	input  am_pkg::layer_word_t [am_pkg::n_layers-1:0] lay_in,	// Registered FIFO data
	output am_pkg::layer_word_t [am_pkg::n_layers-1:0] word,
	output logic [am_pkg::n_layers-1:0]                word_valid,
	input  logic [am_pkg::n_layers-1:0]                word_ready
);
	import am_pkg::*;

	logic [n_layers-1:0] in_flight;	// Read issued last cycle, data on lay_in now
	logic [n_layers-1:0] skid_ready;	// Skid has a free slot

	// Read only when the returning word is sure to fit
	// Skid cannot fill while nothing is in flight, so ready holds one more cycle
	assign rden_b = ~(ef_b & ~in_flight & skid_ready);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_flight <= '0;
		end else begin
			in_flight <= ~rden_b;	// FIFO answers one cycle after read
		end
	end

	// ********************
	// One skid per layer
	// ********************
	for (genvar k = 0; k < n_layers; k++) begin : g_lay
		word_skid #(
			.payload_t(layer_word_t)
		) u_skid (
			.clk      (clk),
			.rst_n    (rst_n),
			.in_data  (lay_in[k]),	// Captured in the cycle after rden_b
			.in_valid (in_flight[k]),
			.in_ready (skid_ready[k]),
			.out_data (word[k]),
			.out_valid(word_valid[k]),
			.out_ready(word_ready[k])
		);
	end

endmodule

// File: logic/event_fsm.sv
`timescale 1ns/1ns

module event_fsm (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  am_pkg::layer_word_t [am_pkg::n_layers-1:0] word,
	input  logic [am_pkg::n_layers-1:0]                word_valid,
	output logic [am_pkg::n_layers-1:0]                word_ready,
	input  logic [am_pkg::n_lambs-1:0]                 road_end,	// LAMB finished matching
	input  logic                                       collector_idle,
	output am_pkg::hit_bus_t                           lamb_hits,
	output logic                                       init_ev,	// One-cycle event init
	output am_pkg::road_word_t                         ee_word,
	output logic                                       ee_valid,
	input  logic                                       ee_ready
);
	import am_pkg::*;

	typedef enum logic [1:0] {
		st_hits,	// Broadcasting until every layer gave its end-event
		st_roads,	// LAMBs and collector draining
		st_ee	// End-event word offered to output
	} state_t;

	state_t                         state;
	logic [n_layers-1:0]            done;	// End-event seen per layer
	logic [n_layers-1:0]            accept;
	logic [n_layers-1:0]            ee_seen;	// Accepted word is end-event
	logic [n_layers-1:0]            hit_seen;	// Accepted word is a hit
	logic [tag_w-1:0]               tag;	// From layer 0
	logic [n_layers-1:0][hit_w-1:0] hit_q;
	logic [n_layers-1:0]            wr_en_q;
	logic                           ee_fire;

	// Per-layer accept, stalled once done
	always_comb begin
		for (int k = 0; k < n_layers; k++) begin
			word_ready[k] = (state == st_hits) && !done[k];
			accept[k]     = word_valid[k] & word_ready[k];
			ee_seen[k]    = accept[k] & word[k].ee;
			hit_seen[k]   = accept[k] & ~word[k].ee;
		end
	end

	// ********************
	// Event state machine
	// ********************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= st_hits;
			done    <= '0;
			init_ev <= 1'b0;
		end else begin
			init_ev <= 1'b0;	// Pulse only
			case (state)
				st_hits: begin
					done <= done | ee_seen;
					if (&done) begin
						state <= st_roads;
					end
				end
				st_roads: begin
					if (&road_end && collector_idle) begin
						state <= st_ee;	// All roads out of the collector
					end
				end
				st_ee: begin
					if (ee_fire) begin
						state   <= st_hits;	// Next event
						done    <= '0;
						init_ev <= 1'b1;
					end
				end
				default: state <= st_hits;
			endcase
		end
	end

	// Hit bus, enables one cycle per hit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_en_q <= '0;
		end else begin
			wr_en_q <= hit_seen;	// End-event words never reach the bus
		end
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < n_layers; k++) begin
			if (hit_seen[k]) begin
				hit_q[k] <= word[k].payload;
			end
		end
		if (ee_seen[0]) begin
			tag <= word[0].payload[tag_w-1:0];
		end
	end

	assign lamb_hits.hit   = hit_q;
	assign lamb_hits.wr_en = wr_en_q;

	// End-event word, tag zero-extended
	assign ee_valid        = (state == st_ee);
	assign ee_fire         = ee_valid & ee_ready;
	assign ee_word.ee      = 1'b1;
	assign ee_word.lamb    = '0;
	assign ee_word.payload = {{(road_w-tag_w){1'b0}}, tag};

endmodule

// File: logic/road_collector.sv
`timescale 1ns/1ns

module road_collector (
	input  logic                                         clk,
	input  logic                                         rst_n,
	input  logic [am_pkg::n_lambs-1:0]                   dr_b,	// Low while LAMB holds a road
	input  logic [am_pkg::n_lambs-1:0][am_pkg::road_w-1:0] ladd,
	output logic [am_pkg::n_lambs-1:0]                   sel_b,	// Active-low road acknowledge
	output am_pkg::road_word_t                           road,
	output logic                                         road_valid,
	input  logic                                         road_ready,
	output logic                                         idle
);
	import am_pkg::*;

	logic [lamb_idx_w-1:0] ptr;	// LAMB checked this cycle
	logic                  gap;	// Road taken last cycle, LAMB still releasing
	logic                  take;

	// Select only into an empty output register, never two cycles running
	assign take = ~dr_b[ptr] & ~road_valid & ~gap;

	always_comb begin
		sel_b      = '1;
		sel_b[ptr] = ~take;	// Same cycle the road is registered
	end

	// Nothing held here and nothing pending at the LAMBs
	assign idle = ~road_valid & (&dr_b);

	// ********************
	// Round robin
	// ********************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr        <= '0;
			gap        <= 1'b0;
			road_valid <= 1'b0;
		end else begin
			gap <= take;
			if (take) begin
				road_valid <= 1'b1;
			end else if (road_ready) begin
				road_valid <= 1'b0;
			end
			// Move on after a serve or an idle board, wait on a blocked one
			if (take || dr_b[ptr]) begin
				ptr <= (ptr == lamb_idx_w'(n_lambs - 1)) ? '0 : ptr + 1'b1;
			end
		end
	end

	// Road payload
	always_ff @(posedge clk) begin
		if (take) begin
			road <= '{ee: 1'b0, lamb: ptr, payload: ladd[ptr]};
		end
	end

endmodule

// File: logic/road_output.sv
`timescale 1ns/1ns

module road_output (
	input  logic               clk,
	input  logic               rst_n,
	input  am_pkg::road_word_t road,
	input  logic               road_valid,
	output logic               road_ready,
	input  am_pkg::road_word_t ee_word,
	input  logic               ee_valid,
	output logic               ee_ready,
	output am_pkg::road_word_t odata,
	output logic               wr_road,	// Write strobe to next board
	input  logic               rhold_b	// High when downstream can take a word
);
	import am_pkg::*;

	road_word_t merge_data;
	logic       merge_valid;
	logic       merge_ready;
	logic       out_valid;

	// ********************
	// Merge, roads first
	// ********************
	assign merge_data  = road_valid ? road : ee_word;
	assign merge_valid = road_valid | ee_valid;
	assign road_ready  = merge_ready;
	assign ee_ready    = merge_ready & ~road_valid;	// End-event waits behind roads

	word_skid #(
		.payload_t(road_word_t)
	) u_skid (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_data  (merge_data),
		.in_valid (merge_valid),
		.in_ready (merge_ready),
		.out_data (odata),
		.out_valid(out_valid),
		.out_ready(rhold_b)	// Hold stalls the skid, no loss
	);

	// Strobe only when downstream takes it
	assign wr_road = out_valid & rhold_b;

endmodule

// File: logic/am_ctrl_top.sv
`timescale 1ns/1ns

module am_ctrl_top (
	input  logic                                         clk,
	input  logic                                         rst_n,
	input  logic [am_pkg::n_layers-1:0]                  ef_b,	// FIFO empty flags
	input  am_pkg::layer_word_t [am_pkg::n_layers-1:0]   lay_in,
	input  logic [am_pkg::n_lambs-1:0]                   dr_b,
	input  logic [am_pkg::n_lambs-1:0][am_pkg::road_w-1:0] ladd,
	input  logic [am_pkg::n_lambs-1:0]                   road_end,
	input  logic                                         rhold_b,
	output logic [am_pkg::n_layers-1:0]                  rden_b,
	output am_pkg::hit_bus_t                             lamb_hits,	// Shared by all LAMBs
	output logic                                         init_ev,
	output logic [am_pkg::n_lambs-1:0]                   sel_b,
	output am_pkg::road_word_t                           odata,
	output logic                                         wr_road
);
	import am_pkg::*;

	// Layer streams
	layer_word_t [n_layers-1:0] word;
	logic [n_layers-1:0]        word_valid;
	logic [n_layers-1:0]        word_ready;

	// Road and end-event paths
	road_word_t road;
	logic       road_valid;
	logic       road_ready;
	logic       collector_idle;
	road_word_t ee_word;
	logic       ee_valid;
	logic       ee_ready;

	// ********************
	// Input side
	// ********************
	layer_input u_layer_input (
		.clk       (clk),
		.rst_n     (rst_n),
		.ef_b      (ef_b),
		.rden_b    (rden_b),
		.lay_in    (lay_in),
		.word      (word),
		.word_valid(word_valid),
		.word_ready(word_ready)
	);

	event_fsm u_event_fsm (
		.clk           (clk),
		.rst_n         (rst_n),
		.word          (word),
		.word_valid    (word_valid),
		.word_ready    (word_ready),
		.road_end      (road_end),
		.collector_idle(collector_idle),
		.lamb_hits     (lamb_hits),
		.init_ev       (init_ev),
		.ee_word       (ee_word),
		.ee_valid      (ee_valid),
		.ee_ready      (ee_ready)
	);

	// ********************
	// Road side
	// ********************
	road_collector u_road_collector (
		.clk       (clk),
		.rst_n     (rst_n),
		.dr_b      (dr_b),
		.ladd      (ladd),
		.sel_b     (sel_b),
		.road      (road),
		.road_valid(road_valid),
		.road_ready(road_ready),
		.idle      (collector_idle)
	);

	road_output u_road_output (
		.clk       (clk),
		.rst_n     (rst_n),
		.road      (road),
		.road_valid(road_valid),
		.road_ready(road_ready),
		.ee_word   (ee_word),
		.ee_valid  (ee_valid),
		.ee_ready  (ee_ready),
		.odata     (odata),
		.wr_road   (wr_road),
		.rhold_b   (rhold_b)
	);

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 20 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;	// Release on a rising edge
	end

endmodule

// File: verif/am_ctrl_checker.sv
`timescale 1ns/1ns

module am_ctrl_checker (
	input logic                          clk,
	input logic                          rst_n,
	input logic [am_pkg::n_layers-1:0]   rden_b,
	input am_pkg::hit_bus_t              lamb_hits,
	input logic                          init_ev,
	input logic [am_pkg::n_lambs-1:0]    sel_b,
	input am_pkg::road_word_t            odata,
	input logic                          wr_road,
	input logic                          rhold_b
);
	import am_pkg::*;

	logic [hit_w-1:0]  exp_hit [n_layers][$];	// Per layer, FIFO order
	logic [road_w-1:0] exp_road [n_lambs][$];	// Per LAMB, FIFO order
	logic [tag_w-1:0]  tag;
	logic [road_w-1:0] act_val;
	string             name;
	bit                active;	// A test row is running
	bit                got_ee;
	bit                got_init;
	int                errs;
	int                sel_cnt;	// sel_b pulses this row
	int                road_total;
	int                n_pass;
	int                n_fail;

	// ********************
	// Calls from the testbench
	// ********************
	task automatic start_test(input string row, input logic [tag_w-1:0] row_tag);
		name       = row;
		tag        = row_tag;
		errs       = 0;
		sel_cnt    = 0;
		road_total = 0;
		got_ee     = 1'b0;
		got_init   = 1'b0;
		active     = 1'b1;
	endtask

	task automatic add_hit(input int k, input logic [hit_w-1:0] v);
		exp_hit[k].push_back(v);
	endtask

	task automatic add_road(input int j, input logic [road_w-1:0] v);
		exp_road[j].push_back(v);
		road_total++;
	endtask

	task automatic end_test();
		for (int k = 0; k < n_layers; k++) begin
			if (exp_hit[k].size() != 0) begin
				$display("%s: %0d hits never written on layer %0d", name, exp_hit[k].size(), k);
				errs++;
				exp_hit[k].delete();
			end
		end
		for (int j = 0; j < n_lambs; j++) begin
			if (exp_road[j].size() != 0) begin
				$display("%s: %0d roads of LAMB %0d never output", name, exp_road[j].size(), j);
				errs++;
				exp_road[j].delete();
			end
		end
		if (!got_ee) begin
			$display("%s: no end-event word was output", name);
			errs++;
		end
		if (!got_init) begin
			$display("%s: no init_ev pulse", name);
			errs++;
		end
		if (sel_cnt != road_total) begin
			$display("%s: %0d sel_b pulses for %0d roads", name, sel_cnt, road_total);
			errs++;
		end
		active = 1'b0;
		if (errs == 0) begin
			$display("row %s: ok", name);
			n_pass++;
		end else begin
			$display("row %s: %0d errors", name, errs);
			n_fail++;
		end
	endtask

	task automatic report();
		$display("rows ok %0d, rows with errors %0d", n_pass, n_fail);
	endtask

	// ********************
	// Output monitor
	// ********************
	always @(posedge clk) begin
		if (rst_n && !active) begin
			// Nothing loaded, so every output must rest
			if (rden_b != '1 || sel_b != '1 || wr_road || init_ev || lamb_hits.wr_en != '0) begin
				$display("DUT outputs active while no test is running");
				n_fail++;
			end
		end else if (rst_n) begin
			for (int k = 0; k < n_layers; k++) begin
				if (lamb_hits.wr_en[k]) begin
					if (exp_hit[k].size() == 0) begin
						$display("%s: extra hit %h on layer %0d", name, lamb_hits.hit[k], k);
						errs++;
					end else if (exp_hit[k][0] != lamb_hits.hit[k]) begin
						$display("Mismatch %s: layer %0d expected %h actual %h", name, k,
							exp_hit[k].pop_front(), lamb_hits.hit[k]);
						errs++;
					end else begin
						void'(exp_hit[k].pop_front());
					end
				end
			end
			for (int j = 0; j < n_lambs; j++) begin
				if (!sel_b[j]) sel_cnt++;
			end
			if (wr_road && !rhold_b) begin
				$display("%s: wr_road high while rhold_b low", name);
				errs++;
			end
			if (wr_road && odata.ee) begin
				act_val = road_w'(tag);
				for (int j = 0; j < n_lambs; j++) begin
					if (exp_road[j].size() != 0) begin
						$display("%s: end-event word before roads of LAMB %0d", name, j);
						errs++;
					end
				end
				if (got_ee) begin
					$display("%s: second end-event word", name);
					errs++;
				end else if (odata.payload != act_val || odata.lamb != '0) begin
					$display("Mismatch %s: end-event expected %h actual %h", name,
						{1'b1, 2'b00, act_val}, odata);
					errs++;
				end
				got_ee = 1'b1;
			end else if (wr_road) begin
				if (exp_road[odata.lamb].size() == 0) begin
					$display("%s: extra road %h from LAMB %0d", name, odata.payload, odata.lamb);
					errs++;
				end else begin
					act_val = exp_road[odata.lamb].pop_front();
					if (act_val != odata.payload) begin
						$display("Mismatch %s: LAMB %0d road expected %h actual %h", name,
							odata.lamb, act_val, odata.payload);
						errs++;
					end
				end
			end
			// Event init may lead the end-event word while the output is held
			if (init_ev) begin
				if (got_init) begin
					$display("%s: extra init_ev pulse", name);
					errs++;
				end
				for (int k = 0; k < n_layers; k++) begin
					if (exp_hit[k].size() != 0) begin
						$display("%s: init_ev before all hits of layer %0d", name, k);
						errs++;
					end
				end
				got_init = 1'b1;
			end
		end
	end

endmodule

// File: verif/am_ctrl_tb.sv
`timescale 1ns/1ns

module am_ctrl_tb;
	import am_pkg::*;

	localparam int n_rows = 5;

	logic                             clk;
	logic                             rst_n;
	logic [n_layers-1:0]              ef_b;
	logic [n_layers-1:0]              rden_b;
	layer_word_t [n_layers-1:0]       lay_in;
	logic [n_lambs-1:0]               dr_b;
	logic [n_lambs-1:0][road_w-1:0]   ladd;
	logic [n_lambs-1:0]               road_end;
	logic [n_lambs-1:0]               sel_b;
	logic                             rhold_b;
	hit_bus_t                         lamb_hits;
	logic                             init_ev;
	road_word_t                       odata;
	logic                             wr_road;

	// ********************
	// Test table
	// ********************
	string            row_name [n_rows];
	int               hit_cnt [n_rows][n_layers];
	int               road_cnt [n_rows][n_lambs];
	logic [tag_w-1:0] row_tag [n_rows];
	bit               row_hold [n_rows];	// Random downstream hold

	layer_word_t       fq [n_layers][$];	// FIFO model contents
	logic [road_w-1:0] lq [n_lambs][$];	// Roads waiting in each LAMB
	bit                hold_on;
	int                seed;
	int                cycles;
	int                limit;
	int                match_wait;	// Cycles until the LAMBs finish matching
	logic [hit_w-1:0]  hv;
	logic [road_w-1:0] rv;

	tb_clock u_clock (.clk(clk), .rst_n(rst_n));

	am_ctrl_top uut (
		.clk(clk), .rst_n(rst_n), .ef_b(ef_b), .lay_in(lay_in), .dr_b(dr_b), .ladd(ladd),
		.road_end(road_end), .rhold_b(rhold_b), .rden_b(rden_b), .lamb_hits(lamb_hits),
		.init_ev(init_ev), .sel_b(sel_b), .odata(odata), .wr_road(wr_road)
	);

	am_ctrl_checker chk (
		.clk(clk), .rst_n(rst_n), .rden_b(rden_b), .lamb_hits(lamb_hits), .init_ev(init_ev),
		.sel_b(sel_b), .odata(odata), .wr_road(wr_road), .rhold_b(rhold_b)
	);

	// FIFOs, LAMBs and downstream hold
	always @(posedge clk) begin
		if (rst_n) begin
			for (int k = 0; k < n_layers; k++) begin
				if (!rden_b[k] && fq[k].size() > 0) lay_in[k] <= fq[k].pop_front();	// Registered read
				ef_b[k] <= (fq[k].size() > 0) && (($random(seed) & 7) != 0);	// Random gaps
			end
			// LAMBs keep matching for a while after the last hit
			if (lamb_hits.wr_en != '0) begin
				match_wait = 8;
			end else if (match_wait > 0) begin
				match_wait--;
			end
			for (int j = 0; j < n_lambs; j++) begin
				if (!sel_b[j]) begin
					if (lq[j].size() > 0) void'(lq[j].pop_front());
					dr_b[j] <= 1'b1;	// Release after acknowledge
				end else if (dr_b[j] && lq[j].size() > 0 && match_wait == 0) begin
					dr_b[j] <= 1'b0;
					ladd[j] <= lq[j][0];
				end
				road_end[j] <= (lq[j].size() == 0) && (match_wait == 0);
			end
			rhold_b <= hold_on ? (($random(seed) & 3) != 0) : 1'b1;
		end
	end

	// Run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout after %0d cycles, expected words still missing", cycles);
			$display("test failed");
			$finish;
		end
	end

	initial begin
		seed       = 32'hde9e_abb1;
		cycles     = 0;
		match_wait = 0;
		hold_on    = 1'b0;
		ef_b       = '0;
		lay_in     = '0;
		dr_b       = '1;
		ladd       = '0;
		road_end   = '1;
		rhold_b    = 1'b1;
		row_name = '{"single_hits", "many_hits", "empty_layers", "hold_random", "no_hits"};
		hit_cnt  = '{'{1, 1, 1, 1, 1, 1}, '{4, 3, 2, 5, 1, 3}, '{0, 2, 0, 0, 1, 0},
			'{3, 3, 3, 3, 3, 3}, '{0, 0, 0, 0, 0, 0}};
		road_cnt = '{'{1, 0, 0, 0}, '{2, 1, 3, 1}, '{0, 0, 0, 0}, '{4, 4, 4, 4}, '{0, 0, 0, 0}};
		row_tag  = '{16'h0001, 16'h1234, 16'hbeef, 16'h55aa, 16'h0ff0};
		row_hold = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
		limit = 16 + 40;	// Reset and quiet window
		for (int r = 0; r < n_rows; r++) begin
			limit += 8 * 10;
			for (int k = 0; k < n_layers; k++) limit += 8 * hit_cnt[r][k];
			for (int j = 0; j < n_lambs; j++) limit += 8 * road_cnt[r][j];
		end

		wait (rst_n);
		repeat (10) @(posedge clk);	// Outputs must rest with FIFOs empty
		for (int r = 0; r < n_rows; r++) begin
			@(negedge clk);
			chk.start_test(row_name[r], row_tag[r]);
			hold_on    = row_hold[r];
			match_wait = 24;	// Matching runs until after the hits
			for (int k = 0; k < n_layers; k++) begin
				for (int i = 0; i < hit_cnt[r][k]; i++) begin
					hv = hit_w'(r * 4096 + k * 256 + i * 7 + 1);
					fq[k].push_back('{ee: 1'b0, spare: 2'b00, payload: hv});
					chk.add_hit(k, hv);
				end
				fq[k].push_back('{ee: 1'b1, spare: 2'b00, payload: hit_w'(row_tag[r])});
			end
			for (int j = 0; j < n_lambs; j++) begin
				for (int i = 0; i < road_cnt[r][j]; i++) begin
					rv = road_w'(r * 65536 + j * 4096 + i * 3 + 5);
					lq[j].push_back(rv);
					chk.add_road(j, rv);
				end
			end
			@(negedge clk);
			while (!(chk.got_ee && chk.got_init)) @(negedge clk);
			@(negedge clk);
			chk.end_test();
		end
		repeat (4) @(posedge clk);
		chk.report();
		if (chk.n_fail == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: flist.f
logic/am_pkg.sv
logic/word_skid.sv
logic/layer_input.sv
logic/event_fsm.sv
logic/road_collector.sv
logic/road_output.sv
logic/am_ctrl_top.sv
verif/tb_clock.sv
verif/am_ctrl_checker.sv
verif/am_ctrl_tb.sv

// File: run.sh
#!/bin/sh
# Build and run with Verilator, then judge the log
rm -f sim.log
{ verilator --binary -Wno-fatal -f flist.f --top-module am_ctrl_tb -o am_ctrl_sim > build.log 2>&1 &&
	./obj_dir/am_ctrl_sim > sim.log 2>&1; } || echo "test failed" >> sim.log
grep -q "test failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } || { echo "PASS"; exit 0; }
